/* include/uart_rx_settings.svh */
////////////////////
// build settings for the uart receiver
// oversampling, sample point, fifo depth, sink credits
////////////////////

`ifndef UART_RX_SETTINGS_SVH
`define UART_RX_SETTINGS_SVH

// rxclk cycles per serial bit
`define UART_OVERSAMPLE 16

// count within a bit window where the line is read
// start detect cycle counts as zero, so 7 lands mid bit
`define UART_SAMPLE_POINT 7

// fifo entries, also the receiver credits after reset
`define RX_FIFO_DEPTH 8

// sink credits held by the unloader after reset
`define OUT_CREDITS 4

`endif

/* source/uart_rx_pkg.sv */
////////////////////
// shared types for the uart receiver
// receiver states, data byte, status counts
////////////////////

package uart_rx_pkg;

   // receiver fsm states
   typedef enum logic [1:0]
   {
      IDLE  = 2'd0,
      START = 2'd1,
      DATA  = 2'd2,
      STOP  = 2'd3
   } rx_state_e;

   // one received character
   typedef struct packed
   {
      logic [7:0] data;
   } rx_byte_t;

   // error counts, both saturate at 8'hff
   // frames with a low stop bit land in frame_err_count
   // good frames dropped for lack of fifo credit land in overrun_count
   typedef struct packed
   {
      logic [7:0] frame_err_count;
      logic [7:0] overrun_count;
   } rx_status_t;

endpackage

/* source/uart_frame_receiver.sv */
////////////////////
// uart frame receiver
// sync, start detect, mid bit sampling, credit push
////////////////////

`timescale 1ns/100ps

`include "uart_rx_settings.svh"

module uart_frame_receiver
   import uart_rx_pkg::*;
(
   input  logic       rxclk,
   input  logic       reset,
   input  logic       rx_in,
   input  logic       rx_enable,
   input  logic       fifo_credit,
   output logic       push_valid,
   output rx_byte_t   push_byte,
   output rx_status_t status
);

   localparam int CREDIT_W = $clog2(`RX_FIFO_DEPTH + 1);
   localparam logic [3:0] SAMPLE_POINT = 4'(`UART_SAMPLE_POINT);
   localparam logic [3:0] SAMPLE_LAST = 4'(`UART_OVERSAMPLE - 1);

   logic                rx_d1;
   logic                rx_d2;
   rx_state_e           state;
   logic [3:0]          sample_cnt;
   logic [3:0]          bit_cnt;
   logic [7:0]          shift_reg;
   logic [CREDIT_W-1:0] credits;
   logic                sample_tick;
   logic                stop_tick;
   logic                do_push;

   // two flop synchronizer that resets to the idle high level
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         rx_d1 <= 1'b1;
         rx_d2 <= 1'b1;
      end
      else
      begin
         rx_d1 <= rx_in;
         rx_d2 <= rx_d1;
      end
   end

   assign sample_tick = rx_enable && (state != IDLE) && (sample_cnt == SAMPLE_POINT);
   assign stop_tick   = sample_tick && (state == STOP);

   // good stop bit and a free fifo entry
   assign do_push = stop_tick && rx_d2 && (credits != '0);

   // frame fsm
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         state      <= IDLE;
         sample_cnt <= '0;
         bit_cnt    <= '0;
      end
      else if (!rx_enable)
      begin
         // drop whatever frame was in progress
         state <= IDLE;
      end
      else if (state == IDLE)
      begin
         if (!rx_d2)
         begin
            // this cycle is sample zero of the start bit
            state      <= START;
            sample_cnt <= 4'd1;
            bit_cnt    <= '0;
         end
      end
      else
      begin
         sample_cnt <= (sample_cnt == SAMPLE_LAST) ? '0 : sample_cnt + 4'd1;
         if (sample_tick)
         begin
            case (state)
               START:
               begin
                  // high at mid start bit means a glitch
                  if (rx_d2)
                     state <= IDLE;
                  else
                     state <= DATA;
               end
               DATA:
               begin
                  bit_cnt <= bit_cnt + 4'd1;
                  if (bit_cnt == 4'd7)
                     state <= STOP;
               end
               default:
                  state <= IDLE;
            endcase
         end
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge rxclk)
   begin
      if (sample_tick && (state == DATA))
         shift_reg <= {rx_d2, shift_reg[7:1]};
      if (do_push)
         push_byte.data <= shift_reg;
   end

   // fifo credits are spent on push and returned on pop
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         push_valid <= 1'b0;
         credits    <= CREDIT_W'(`RX_FIFO_DEPTH);
      end
      else
      begin
         push_valid <= do_push;
         case ({do_push, fifo_credit})
            2'b10:   credits <= credits - CREDIT_W'(1);
            2'b01:   credits <= credits + CREDIT_W'(1);
            default: credits <= credits;
         endcase
      end
   end

   // error counts
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         status <= '0;
      end
      else if (stop_tick)
      begin
         if (!rx_d2)
         begin
            if (status.frame_err_count != 8'hff)
               status.frame_err_count <= status.frame_err_count + 8'd1;
         end
         else if (credits == '0)
         begin
            if (status.overrun_count != 8'hff)
               status.overrun_count <= status.overrun_count + 8'd1;
         end
      end
   end

endmodule

/* source/rx_byte_fifo.sv */
////////////////////
// receive byte fifo
// circular buffer, credit per popped entry
////////////////////

`timescale 1ns/100ps

`include "uart_rx_settings.svh"

module rx_byte_fifo
   import uart_rx_pkg::*;
(
   input  logic     rxclk,
   input  logic     reset,
   input  logic     push_valid,
   input  rx_byte_t push_byte,
   input  logic     pop,
   output logic     fifo_empty,
   output rx_byte_t fifo_head,
   output logic     fifo_credit
);

   localparam int PTR_W = $clog2(`RX_FIFO_DEPTH);
   localparam int CNT_W = $clog2(`RX_FIFO_DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`RX_FIFO_DEPTH - 1);

   rx_byte_t         mem [`RX_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // the receiver never pushes into a full fifo
   always_ff @(posedge rxclk)
   begin
      if (push_valid)
         mem[wr_ptr] <= push_byte;
   end

   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         fifo_credit <= 1'b0;
      end
      else
      begin
         if (push_valid)
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + PTR_W'(1);
         if (pop)
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + PTR_W'(1);

         case ({push_valid, pop})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;
         endcase

         // freed entry goes back to the receiver one cycle later
         fifo_credit <= pop;
      end
   end

   assign fifo_empty = (count == '0);
   assign fifo_head  = mem[rd_ptr];

endmodule

/* source/rx_credit_unloader.sv */
////////////////////
// fifo unloader toward the sink
// pops while sink credits remain
////////////////////

`timescale 1ns/100ps

`include "uart_rx_settings.svh"

module rx_credit_unloader
   import uart_rx_pkg::*;
(
   input  logic     rxclk,
   input  logic     reset,
   input  logic     fifo_empty,
   input  rx_byte_t fifo_head,
   input  logic     out_credit,
   output logic     pop,
   output logic     out_valid,
   output rx_byte_t out_byte
);

   localparam int CREDIT_W = $clog2(`OUT_CREDITS + 1);

   logic [CREDIT_W-1:0] credits;

   // one byte per cycle while data and credit are both there
   assign pop = !fifo_empty && (credits != '0);

   // sink credit count where a pop and a returned credit may coincide
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
      begin
         credits <= CREDIT_W'(`OUT_CREDITS);
      end
      else
      begin
         case ({pop, out_credit})
            2'b10:   credits <= credits - CREDIT_W'(1);
            2'b01:   credits <= credits + CREDIT_W'(1);
            default: credits <= credits;
         endcase
      end
   end

   // out_valid is a one cycle strobe without handshake
   always_ff @(posedge rxclk or posedge reset)
   begin
      if (reset)
         out_valid <= 1'b0;
      else
         out_valid <= pop;
   end

   // payload follows the popped head
   always_ff @(posedge rxclk)
   begin
      if (pop)
         out_byte <= fifo_head;
   end

endmodule

/* source/uart_rx_top.sv */
////////////////////
// uart receive path top level
////////////////////

`timescale 1ns/100ps

module uart_rx_top
   import uart_rx_pkg::*;
(
   input  logic       rxclk,
   input  logic       reset,
   input  logic       rx_in,
   input  logic       rx_enable,
   input  logic       out_credit,
   output logic       out_valid,
   output rx_byte_t   out_byte,
   output rx_status_t status
);

   // receiver to fifo
   logic     push_valid;
   rx_byte_t push_byte;
   logic     fifo_credit;

   // fifo to unloader
   logic     fifo_empty;
   rx_byte_t fifo_head;
   logic     pop;

   uart_frame_receiver receiver
   (
      .rxclk       (rxclk),
      .reset       (reset),
      .rx_in       (rx_in),
      .rx_enable   (rx_enable),
      .fifo_credit (fifo_credit),
      .push_valid  (push_valid),
      .push_byte   (push_byte),
      .status      (status)
   );

   rx_byte_fifo fifo
   (
      .rxclk       (rxclk),
      .reset       (reset),
      .push_valid  (push_valid),
      .push_byte   (push_byte),
      .pop         (pop),
      .fifo_empty  (fifo_empty),
      .fifo_head   (fifo_head),
      .fifo_credit (fifo_credit)
   );

   rx_credit_unloader unloader
   (
      .rxclk      (rxclk),
      .reset      (reset),
      .fifo_empty (fifo_empty),
      .fifo_head  (fifo_head),
      .out_credit (out_credit),
      .pop        (pop),
      .out_valid  (out_valid),
      .out_byte   (out_byte)
   );

endmodule

/* bench/uart_rx_tb.sv */
////////////////////
// testbench for the uart receive path
// serial line model, credit sink, scoreboard, watchdog
////////////////////

`timescale 1ns/100ps

`include "uart_rx_settings.svh"

module uart_rx_tb
   import uart_rx_pkg::*;
();

   localparam int bit_cycles      = `UART_OVERSAMPLE;
   localparam int frame_total     = 54;
   localparam int watchdog_cycles = frame_total * 10 * bit_cycles + 4000;
   localparam int drain_limit     = 200;

   logic       rxclk;
   logic       reset;
   logic       rx_in;
   logic       rx_enable;
   logic       out_credit = 1'b0;
   logic       out_valid;
   rx_byte_t   out_byte;
   rx_status_t status;

   // expected bytes written by the stimulus and read by the scoreboard
   logic [7:0] exp_bytes [0:255];
   logic [7:0] wr_idx = 8'd0;
   logic [7:0] rd_idx = 8'd0;
   rx_status_t exp_status = '0;

   // reference model of fifo fill and sink credits
   int         model_level = 0;
   int         model_credits = `OUT_CREDITS;
   logic       model_hold = 1'b0;
   logic       hold_credits = 1'b0;

   int         sink_credits = `OUT_CREDITS;
   int         pending_credits = 0;
   logic [31:0] rng_state = 32'd14;

   int         byte_mismatches = 0;
   int         status_mismatches = 0;
   int         credit_failures = 0;
   int         order_failures = 0;
   int         other_failures = 0;

   uart_rx_top UUT
   (
      .rxclk      (rxclk),
      .reset      (reset),
      .rx_in      (rx_in),
      .rx_enable  (rx_enable),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .out_byte   (out_byte),
      .status     (status)
   );

   initial
   begin
      rxclk = 1'b0;
      forever #2 rxclk = ~rxclk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int pending_count();
      return int'(8'(wr_idx - rd_idx));
   endfunction

   // every strobe must match the oldest expected byte
   always @(posedge rxclk)
   begin
      if (!reset && out_valid)
      begin
         assert (wr_idx != rd_idx)
         else
         begin
            order_failures++;
            $display("byte %h came out while no byte was expected", out_byte.data);
         end
         if (wr_idx != rd_idx)
         begin
            assert (out_byte.data == exp_bytes[rd_idx])
            else
            begin
               byte_mismatches++;
               $display("Mismatch out_byte: got %h, expected %h",
                        out_byte.data, exp_bytes[rd_idx]);
            end
            rd_idx <= rd_idx + 8'd1;
         end
      end
   end

   // sink model returns one credit per absorbed byte unless held
   always @(posedge rxclk)
   begin
      if (!reset)
      begin
         if (out_valid)
         begin
            assert (sink_credits > 0)
            else
            begin
               credit_failures++;
               $display("out_valid rose while the unloader held no sink credit");
            end
            sink_credits--;
            pending_credits++;
         end
         if (out_credit)
            sink_credits++;
         if (!hold_credits && pending_credits > 0)
         begin
            out_credit <= 1'b1;
            pending_credits--;
         end
         else
            out_credit <= 1'b0;
      end
   end

   // bytes reach the sink while the model still has credit for them
   task automatic model_drain();
      while (model_level > 0 && (!model_hold || model_credits > 0))
      begin
         model_level--;
         if (model_hold)
            model_credits--;
      end
   endtask

   task automatic model_frame(input logic [7:0] value, input logic good_stop);
      if (!good_stop)
      begin
         if (exp_status.frame_err_count != 8'hff)
            exp_status.frame_err_count = exp_status.frame_err_count + 8'd1;
      end
      else if (model_level < `RX_FIFO_DEPTH)
      begin
         exp_bytes[wr_idx] = value;
         wr_idx = wr_idx + 8'd1;
         model_level++;
         model_drain();
      end
      else if (exp_status.overrun_count != 8'hff)
         exp_status.overrun_count = exp_status.overrun_count + 8'd1;
   endtask

   task automatic drive_line(input logic level, input int cycles);
      rx_in <= level;
      repeat (cycles) @(posedge rxclk);
   endtask

   task automatic check_status();
      assert (status == exp_status)
      else
      begin
         status_mismatches++;
         $display("Mismatch status: got %h, expected %h", status, exp_status);
      end
   endtask

   // one 8N1 frame where a bad stop bit stays low just past the sample point
   task automatic send_frame(input logic [7:0] value, input logic good_stop,
                             input logic listening);
      logic [7:0] bits;
      bits = value;
      drive_line(1'b0, bit_cycles);
      repeat (8)
      begin
         drive_line(bits[0], bit_cycles);
         bits = bits >> 1;
      end
      if (listening)
         model_frame(value, good_stop);
      if (good_stop)
         drive_line(1'b1, bit_cycles);
      else
      begin
         drive_line(1'b0, `UART_SAMPLE_POINT + 1);
         drive_line(1'b1, bit_cycles - `UART_SAMPLE_POINT - 1);
      end
      check_status();
   endtask

   task automatic send_random(input logic listening);
      rng_state = xorshift32(rng_state);
      send_frame(rng_state[7:0], 1'b1, listening);
   endtask

   task automatic hold_sink(input logic on);
      hold_credits <= on;
      model_hold = on;
      model_credits = `OUT_CREDITS;
      if (!on)
         model_drain();
   endtask

   task automatic wait_drain(input int limit);
      int waited;
      waited = 0;
      while (pending_count() > 0 && waited < limit)
      begin
         @(posedge rxclk);
         waited++;
      end
      assert (pending_count() == 0)
      else
      begin
         other_failures++;
         $display("%0d expected bytes never came out", pending_count());
      end
      // returned credits settle before the next test
      repeat (16) @(posedge rxclk);
   endtask

   task automatic check_held(input int settle);
      repeat (settle) @(posedge rxclk);
      assert (pending_count() == model_level)
      else
      begin
         other_failures++;
         $display("with credits held %0d bytes are still waiting, %0d should be",
                  pending_count(), model_level);
      end
   endtask

   initial
   begin
      int total;
      reset = 1'b1;
      rx_in = 1'b1;
      rx_enable = 1'b1;
      repeat (8) @(posedge rxclk);
      reset <= 1'b0;
      repeat (4) @(posedge rxclk);

      // random bytes back to back
      repeat (20) send_random(1'b1);
      wait_drain(drain_limit);

      // framing error followed by a good frame
      send_frame(8'ha5, 1'b0, 1'b1);
      send_random(1'b1);
      wait_drain(drain_limit);

      // sink stalled until the fifo just fills
      hold_sink(1'b1);
      repeat (`OUT_CREDITS + `RX_FIFO_DEPTH) send_random(1'b1);
      check_held(64);
      hold_sink(1'b0);
      wait_drain(drain_limit);

      // sink stalled with three frames too many
      hold_sink(1'b1);
      repeat (15) send_random(1'b1);
      check_held(64);
      hold_sink(1'b0);
      wait_drain(drain_limit);

      // short low pulse must not start a frame
      // line stays high long enough for a false frame to finish
      drive_line(1'b0, bit_cycles / 2 - 2);
      drive_line(1'b1, 11 * bit_cycles);
      check_status();

      // receiver disabled and then enabled again
      rx_enable <= 1'b0;
      repeat (3) send_random(1'b0);
      rx_enable <= 1'b1;
      drive_line(1'b1, bit_cycles);
      send_random(1'b1);
      wait_drain(drain_limit);

      total = byte_mismatches + status_mismatches + credit_failures
              + order_failures + other_failures;
      $display("errors: %0d byte, %0d status, %0d credit, %0d order, %0d other",
               byte_mismatches, status_mismatches, credit_failures,
               order_failures, other_failures);
      if (total == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // watchdog
   initial
   begin
      repeat (watchdog_cycles) @(posedge rxclk);
      $display("run did not finish within %0d cycles", watchdog_cycles);
      $display("Result: FAILED");
      $finish;
   end

endmodule

/* files.f */
+incdir+include
source/uart_rx_pkg.sv
source/uart_frame_receiver.sv
source/rx_byte_fifo.sv
source/rx_credit_unloader.sv
source/uart_rx_top.sv
bench/uart_rx_tb.sv

/* Makefile */
# Verilator build for the uart receive path

VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = uart_rx_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_TEXT = Result: PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
